/* sources.f */
verilog/list_pkg.sv
verilog/cmd_pkg.sv
verilog/list_table.sv
verilog/upt_fetch.sv
verilog/upt_execute.sv
verilog/upt_writeback.sv
verilog/qry_pipe.sv
verilog/sorted_lists_top.sv
tb/sorted_lists_asserts.sv
tb/tb_sorted_lists.sv

/* Makefile */
TOP := tb_sorted_lists

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

# Passes only when the pass message shows up in the output
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) | awk '{ print } /^All tests passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* tb/tb_sorted_lists.sv */
/*
 * Testbench for the key list store
 * Drives updates and queries, predicts every response with a model
 * of all lists and checks the DUT outputs two falling edges later.
 */
`timescale 1ns/1ns

module tb_sorted_lists;
  import list_pkg::*;
  import cmd_pkg::*;

  // Tests need a little over 200 cycles
  localparam int max_cycles = 3000;

  // Expected outputs for one driven cycle
  typedef struct packed {
    logic     upt;
    logic     err;
    list_id_t id;
    logic     qry;
    key_t     key;
    size_t    size;
    logic     qerr;
    count_t   cnt;
  } expect_t;

  logic     clk;
  logic     rst;
  logic     upt_vld;
  list_id_t upt_id;
  op_t      upt_op;
  key_t     upt_key;
  size_t    upt_size;
  logic     upt_error_vld;
  list_id_t upt_error_id;
  logic     qry_vld;
  list_id_t qry_id;
  level_t   qry_level;
  logic     qry_resp_vld;
  key_t     qry_key;
  size_t    qry_size;
  logic     qry_error;
  count_t   qry_listsize;

  list_state_t model [num_lists];
  expect_t     pend [3];
  // Test name of each pending check
  string       pend_name [1:2];
  key_t        keys [8];
  string       test_name;
  int          seed;
  int          checks;
  int          errors;
  int          cycle_cnt;

  sorted_lists_top i_dut (.*);

  bind sorted_lists_top sorted_lists_asserts u_asserts (
      .clk           (clk)
    , .rst           (rst)
    , .upt_vld       (upt_vld)
    , .upt_id        (upt_id)
    , .upt_error_vld (upt_error_vld)
    , .upt_error_id  (upt_error_id)
    , .qry_vld       (qry_vld)
    , .qry_resp_vld  (qry_resp_vld)
    , .qry_listsize  (qry_listsize)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
    $display("Some tests failed");
    $finish;
  end

  task automatic compare(string what, logic [63:0] exp, logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", pend_name[2], what, exp, act);
    end
  endtask

  // Outputs of the cycle driven two falling edges ago
  task automatic check_outputs();
    compare("upt_error_vld", 64'(pend[2].upt && pend[2].err), 64'(upt_error_vld));
    if (pend[2].upt && pend[2].err) begin
      compare("upt_error_id", 64'(pend[2].id), 64'(upt_error_id));
    end
    compare("qry_resp_vld", 64'(pend[2].qry), 64'(qry_resp_vld));
    if (pend[2].qry) begin
      compare("qry_key", pend[2].key, qry_key);
      compare("qry_size", 64'(pend[2].size), 64'(qry_size));
      compare("qry_error", 64'(pend[2].qerr), 64'(qry_error));
      compare("qry_listsize", 64'(pend[2].cnt), 64'(qry_listsize));
    end
  endtask

  // Outputs are stable at the falling edge
  // New inputs go out right after the check
  task automatic tick();
    @(negedge clk);
    pend[2]      = pend[1];
    pend[1]      = pend[0];
    pend[0]      = '0;
    pend_name[2] = pend_name[1];
    pend_name[1] = test_name;
    check_outputs();
    upt_vld = 1'b0;
    qry_vld = 1'b0;
  endtask

  task automatic idle(int n);
    repeat (n) tick();
  endtask

  // Applies one update to the model and returns the predicted error
  function automatic logic model_update(list_id_t id, op_t op, key_t key, size_t size);
    int free_i;
    int hit_i;
    free_i = -1;
    hit_i  = -1;
    for (int i = 0; i < num_slots; i++) begin
      if (free_i < 0 && !model[id][i].vld) free_i = i;
      if (hit_i < 0 && model[id][i].vld && model[id][i].key == key) hit_i = i;
    end
    case (op)
      OP_CLEAR: model[id] = '0;
      OP_ADD: begin
        if (free_i < 0) return 1'b1;
        model[id][free_i] = entry_t'{vld: 1'b1, key: key, size: size};
      end
      OP_DELETE: begin
        if (hit_i < 0) return 1'b1;
        model[id][hit_i] = '0;
      end
      default: begin
        if (hit_i < 0) return 1'b1;
        model[id][hit_i].size = size;
      end
    endcase
    return 1'b0;
  endfunction

  task automatic send_update(list_id_t id, op_t op, key_t key, size_t size);
    upt_vld     = 1'b1;
    upt_id      = id;
    upt_op      = op;
    upt_key     = key;
    upt_size    = size;
    pend[0].upt = 1'b1;
    pend[0].err = model_update(id, op, key, size);
    pend[0].id  = id;
    tick();
  endtask

  // Expects every update at least three cycles old
  task automatic send_query(list_id_t id, level_t level);
    count_t cnt;
    cnt = '0;
    for (int i = 0; i < num_slots; i++) begin
      if (model[id][i].vld) cnt++;
    end
    qry_vld     = 1'b1;
    qry_id      = id;
    qry_level   = level;
    pend[0].qry = 1'b1;
    pend[0].cnt = cnt;
    if (level < level_t'(num_slots) && model[id][level[1:0]].vld) begin
      pend[0].key  = model[id][level[1:0]].key;
      pend[0].size = model[id][level[1:0]].size;
    end else begin
      pend[0].qerr = 1'b1;
    end
    tick();
  endtask

  task automatic query_list(list_id_t id);
    for (int lv = 0; lv < num_slots; lv++) begin
      send_query(id, level_t'(lv));
    end
  endtask

  function automatic key_t new_key();
    return {$random(seed), $random(seed)};
  endfunction

  // Random ops over a small key pool with ids rotating over span lists
  task automatic random_updates(int n, list_id_t base, int span);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      send_update(base + list_id_t'(i % span), op_t'(r[1:0]), keys[r[4:2]], $random(seed));
    end
  endtask

  initial begin
    key_t  k [num_slots];
    size_t s;
    rst       = 1'b1;
    upt_vld   = 1'b0;
    upt_id    = '0;
    upt_op    = OP_CLEAR;
    upt_key   = '0;
    upt_size  = '0;
    qry_vld   = 1'b0;
    qry_id    = '0;
    qry_level = '0;
    seed      = 17;
    checks    = 0;
    errors    = 0;
    test_name = "reset";
    pend_name[1] = "reset";
    pend_name[2] = "reset";
    for (int i = 0; i < 3; i++) pend[i] = '0;
    for (int i = 0; i < num_lists; i++) model[i] = '0;
    for (int i = 0; i < 8; i++) keys[i] = new_key();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Spaced adds fill slots in order
    test_name = "fill";
    for (int i = 0; i < num_slots; i++) begin
      k[i] = new_key();
      send_update(6'd5, OP_ADD, k[i], $random(seed));
      idle(2);
    end
    query_list(6'd5);

    // Full list rejects an add and out-of-range levels return an error
    test_name = "full";
    send_update(6'd5, OP_ADD, new_key(), $random(seed));
    idle(2);
    query_list(6'd5);
    send_query(6'd5, 8'd4);
    send_query(6'd5, 8'd200);

    // Freed slot is reused and an absent key fails
    test_name = "delete";
    send_update(6'd5, OP_DELETE, k[1], '0);
    idle(2);
    k[1] = new_key();
    send_update(6'd5, OP_ADD, k[1], $random(seed));
    send_update(6'd5, OP_DELETE, new_key(), '0);
    idle(2);
    query_list(6'd5);

    test_name = "replace";
    s = $random(seed);
    send_update(6'd5, OP_REPLACE, k[2], s);
    send_update(6'd5, OP_REPLACE, new_key(), s);
    idle(2);
    query_list(6'd5);

    test_name = "clear";
    send_update(6'd5, OP_CLEAR, '0, '0);
    idle(2);
    query_list(6'd5);

    // Forwarding from execute, writeback and the table
    test_name = "back_to_back";
    for (int span = 1; span <= 3; span++) begin
      random_updates(40, 6'd9, span);
      idle(2);
      for (int i = 0; i < span; i++) query_list(6'd9 + list_id_t'(i));
    end

    idle(4);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tb/sorted_lists_asserts.sv */
/*
 * Protocol checks for the key list store
 * Bound to the top level, checks response latency and output ranges.
 */
`timescale 1ns/1ns

module sorted_lists_asserts (
    input logic               clk
  , input logic               rst
  , input logic               upt_vld
  , input list_pkg::list_id_t upt_id
  , input logic               upt_error_vld
  , input list_pkg::list_id_t upt_error_id
  , input logic               qry_vld
  , input logic               qry_resp_vld
  , input list_pkg::count_t   qry_listsize
);
  import list_pkg::*;

  // Response registers one cycle after the table read
  a_qry_latency: assert property (
    @(posedge clk) disable iff (rst) qry_resp_vld == $past(qry_vld, 2)
  ) else $error("query response not one cycle after the table read");

  // Error pulse belongs to the update two edges back
  a_err_latency: assert property (
    @(posedge clk) disable iff (rst)
      upt_error_vld |-> $past(upt_vld, 2) && (upt_error_id == $past(upt_id, 2))
  ) else $error("error pulse without a matching update two cycles earlier");

  // Valid outputs are always driven
  a_vld_known: assert property (
    @(posedge clk) disable iff (rst)
      !$isunknown(upt_error_vld) && !$isunknown(qry_resp_vld)
  ) else $error("valid output is unknown after reset");

  // Count never exceeds the list capacity
  a_listsize: assert property (
    @(posedge clk) disable iff (rst)
      qry_resp_vld |-> qry_listsize <= count_t'(num_slots)
  ) else $error("query listsize above the number of slots");

endmodule

/* verilog/sorted_lists_top.sv */
/*
 * Key list store, top level
 * Three-stage update pipeline and a one-stage query path over two
 * copies of the list table, both written by the update pipeline.
 */
`timescale 1ns/1ns

module sorted_lists_top (
    input  logic                  clk
  , input  logic                  rst
  // Update channel
  , input  logic                  upt_vld
  , input  list_pkg::list_id_t    upt_id
  , input  cmd_pkg::op_t          upt_op
  , input  list_pkg::key_t        upt_key
  , input  list_pkg::size_t       upt_size
  , output logic                  upt_error_vld
  , output list_pkg::list_id_t    upt_error_id
  // Query channel
  , input  logic                  qry_vld
  , input  list_pkg::list_id_t    qry_id
  , input  cmd_pkg::level_t       qry_level
  , output logic                  qry_resp_vld
  , output list_pkg::key_t        qry_key
  , output list_pkg::size_t       qry_size
  , output logic                  qry_error
  , output list_pkg::count_t      qry_listsize
);
  import list_pkg::*;
  import cmd_pkg::*;

  // Fetch stage register
  logic        f_vld;
  list_id_t    f_id;
  op_t         f_op;
  key_t        f_key;
  size_t       f_size;
  logic [1:0]  f_fwd_sel;
  list_state_t f_fwd_state;

  // Execute result
  logic        exe_vld;
  list_id_t    exe_id;
  list_state_t exe_state;
  logic        exe_error;

  // Writeback, drives both table writes
  logic        wb_vld;
  list_id_t    wb_id;
  list_state_t wb_state;

  // Table read data
  list_state_t upt_tbl_data;
  list_state_t qry_tbl_data;

  upt_fetch u_fetch (
      .clk         (clk)
    , .rst         (rst)
    , .upt_vld     (upt_vld)
    , .upt_id      (upt_id)
    , .upt_op      (upt_op)
    , .upt_key     (upt_key)
    , .upt_size    (upt_size)
    , .exe_vld     (exe_vld)
    , .exe_id      (exe_id)
    , .exe_state   (exe_state)
    , .wb_vld      (wb_vld)
    , .wb_id       (wb_id)
    , .wb_state    (wb_state)
    , .f_vld       (f_vld)
    , .f_id        (f_id)
    , .f_op        (f_op)
    , .f_key       (f_key)
    , .f_size      (f_size)
    , .f_fwd_sel   (f_fwd_sel)
    , .f_fwd_state (f_fwd_state)
  );

  upt_execute u_execute (
      .clk         (clk)
    , .rst         (rst)
    , .f_vld       (f_vld)
    , .f_id        (f_id)
    , .f_op        (f_op)
    , .f_key       (f_key)
    , .f_size      (f_size)
    , .f_fwd_sel   (f_fwd_sel)
    , .f_fwd_state (f_fwd_state)
    , .tbl_data    (upt_tbl_data)
    , .exe_vld     (exe_vld)
    , .exe_id      (exe_id)
    , .exe_state   (exe_state)
    , .exe_error   (exe_error)
  );

  upt_writeback u_writeback (
      .clk           (clk)
    , .rst           (rst)
    , .exe_vld       (exe_vld)
    , .exe_id        (exe_id)
    , .exe_state     (exe_state)
    , .exe_error     (exe_error)
    , .wb_vld        (wb_vld)
    , .wb_id         (wb_id)
    , .wb_state      (wb_state)
    , .upt_error_vld (upt_error_vld)
    , .upt_error_id  (upt_error_id)
  );

  // Read in the request cycle so data lines up with the fetch register
  list_table u_upt_table (
      .clk     (clk)
    , .rd_en   (upt_vld)
    , .rd_addr (upt_id)
    , .wr_en   (wb_vld)
    , .wr_addr (wb_id)
    , .wr_data (wb_state)
    , .rd_data (upt_tbl_data)
  );

  // Query copy, same writes, its own read port
  list_table u_qry_table (
      .clk     (clk)
    , .rd_en   (qry_vld)
    , .rd_addr (qry_id)
    , .wr_en   (wb_vld)
    , .wr_addr (wb_id)
    , .wr_data (wb_state)
    , .rd_data (qry_tbl_data)
  );

  qry_pipe u_qry_pipe (
      .clk          (clk)
    , .rst          (rst)
    , .qry_vld      (qry_vld)
    , .qry_level    (qry_level)
    , .tbl_data     (qry_tbl_data)
    , .qry_resp_vld (qry_resp_vld)
    , .qry_key      (qry_key)
    , .qry_size     (qry_size)
    , .qry_error    (qry_error)
    , .qry_listsize (qry_listsize)
  );

endmodule

/* verilog/qry_pipe.sv */
/*
 * Query stage
 * Selects the requested slot from the query table read, counts the
 * valid slots and registers the response.
 */
`timescale 1ns/1ns

module qry_pipe (
    input  logic                  clk
  , input  logic                  rst
  // Request, table read issued in the same cycle
  , input  logic                  qry_vld
  , input  cmd_pkg::level_t       qry_level
  // Query table read data
  , input  list_pkg::list_state_t tbl_data
  // Response
  , output logic                  qry_resp_vld
  , output list_pkg::key_t        qry_key
  , output list_pkg::size_t       qry_size
  , output logic                  qry_error
  , output list_pkg::count_t      qry_listsize
);
  import list_pkg::*;
  import cmd_pkg::*;

  logic   rd_vld;
  level_t rd_level;
  count_t cnt;
  entry_t ent;
  logic   err;

  // Align request with the registered table output
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld       <= 1'b0;
      qry_resp_vld <= 1'b0;
    end else begin
      rd_vld       <= qry_vld;
      qry_resp_vld <= rd_vld;
    end
  end

  always_comb begin
    cnt = '0;
    for (int i = 0; i < num_slots; i++) begin
      cnt = cnt + count_t'(tbl_data[i].vld);
    end
    // Low bits pick the slot, range check covers the rest
    ent = tbl_data[rd_level[$bits(slot_t)-1:0]];
    err = (rd_level >= level_t'(num_slots)) || !ent.vld;
  end

  always_ff @(posedge clk) begin
    if (qry_vld) begin
      rd_level <= qry_level;
    end
    if (rd_vld) begin
      qry_key      <= err ? '0 : ent.key;
      qry_size     <= err ? '0 : ent.size;
      qry_error    <= err;
      qry_listsize <= cnt;
    end
  end

endmodule

/* verilog/upt_writeback.sv */
/*
 * Update stage 2
 * Holds the new list state for the write into both table copies
 * and reports a failed update as a one-cycle error pulse.
 */
`timescale 1ns/1ns

module upt_writeback (
    input  logic                  clk
  , input  logic                  rst
  // From execute
  , input  logic                  exe_vld
  , input  list_pkg::list_id_t    exe_id
  , input  list_pkg::list_state_t exe_state
  , input  logic                  exe_error
  // Table write, shared by both copies
  , output logic                  wb_vld
  , output list_pkg::list_id_t    wb_id
  , output list_pkg::list_state_t wb_state
  // Error report
  , output logic                  upt_error_vld
  , output list_pkg::list_id_t    upt_error_id
);

  logic wb_error;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_vld <= 1'b0;
    end else begin
      wb_vld <= exe_vld;
    end
  end

  // Failed updates still write, with the unchanged state
  always_ff @(posedge clk) begin
    if (exe_vld) begin
      wb_id    <= exe_id;
      wb_state <= exe_state;
      wb_error <= exe_error;
    end
  end

  // Pulse lasts the single cycle the stage is occupied
  assign upt_error_vld = wb_vld && wb_error;
  assign upt_error_id  = wb_id;

endmodule

/* verilog/upt_execute.sv */
/*
 * Update stage 1
 * Applies CLEAR, ADD, DELETE or REPLACE to the current list state
 * and decides whether the update fails.
 */
`timescale 1ns/1ns

module upt_execute (
    input  logic                  clk
  , input  logic                  rst
  // From fetch
  , input  logic                  f_vld
  , input  list_pkg::list_id_t    f_id
  , input  cmd_pkg::op_t          f_op
  , input  list_pkg::key_t        f_key
  , input  list_pkg::size_t       f_size
  , input  logic [1:0]            f_fwd_sel
  , input  list_pkg::list_state_t f_fwd_state
  // Update table read data, aligned with fetch
  , input  list_pkg::list_state_t tbl_data
  // To writeback
  , output logic                  exe_vld
  , output list_pkg::list_id_t    exe_id
  , output list_pkg::list_state_t exe_state
  , output logic                  exe_error
);
  import list_pkg::*;
  import cmd_pkg::*;

  logic [num_lists-1:0] live;
  list_state_t          cur;
  slot_t                free_idx;
  slot_t                hit_idx;
  logic                 full;
  logic                 no_hit;

  // Lists updated since reset
  // A list not yet touched is treated as empty
  always_ff @(posedge clk) begin
    if (rst) begin
      live <= '0;
    end else if (f_vld) begin
      live[f_id] <= 1'b1;
    end
  end

  // Current list, forwarded state beats the table
  always_comb begin
    if (|f_fwd_sel) begin
      cur = f_fwd_state;
    end else if (live[f_id]) begin
      cur = tbl_data;
    end else begin
      cur = '0;
    end
  end

  // Lowest free slot and lowest valid key match
  // Scan downward so the lowest index is left last
  always_comb begin
    free_idx = '0;
    hit_idx  = '0;
    full     = 1'b1;
    no_hit   = 1'b1;
    for (int i = num_slots - 1; i >= 0; i--) begin
      if (!cur[i].vld) begin
        free_idx = slot_t'(i);
        full     = 1'b0;
      end
      if (cur[i].vld && (cur[i].key == f_key)) begin
        hit_idx = slot_t'(i);
        no_hit  = 1'b0;
      end
    end
  end

  // Apply the operation, a failed one leaves the list as it was
  always_comb begin
    exe_state = cur;
    exe_error = 1'b0;
    case (f_op)
      OP_CLEAR: begin
        exe_state = '0;
      end
      OP_ADD: begin
        exe_error = full;
        if (!full) begin
          exe_state[free_idx].vld  = 1'b1;
          exe_state[free_idx].key  = f_key;
          exe_state[free_idx].size = f_size;
        end
      end
      OP_DELETE: begin
        exe_error = no_hit;
        if (!no_hit) begin
          exe_state[hit_idx] = '0;
        end
      end
      OP_REPLACE: begin
        exe_error = no_hit;
        if (!no_hit) begin
          exe_state[hit_idx].size = f_size;
        end
      end
      default: begin
        exe_error = 1'b1;
      end
    endcase
  end

  assign exe_vld = f_vld;
  assign exe_id  = f_id;

endmodule

/* verilog/upt_fetch.sv */
/*
 * Update stage 0
 * Captures an update request and picks the newest in-flight copy of
 * the same list from the later stages.
 */
`timescale 1ns/1ns

module upt_fetch (
    input  logic                  clk
  , input  logic                  rst
  // Incoming request
  , input  logic                  upt_vld
  , input  list_pkg::list_id_t    upt_id
  , input  cmd_pkg::op_t          upt_op
  , input  list_pkg::key_t        upt_key
  , input  list_pkg::size_t       upt_size
  // Result entering writeback this edge
  , input  logic                  exe_vld
  , input  list_pkg::list_id_t    exe_id
  , input  list_pkg::list_state_t exe_state
  // Writeback, writing the table this edge
  , input  logic                  wb_vld
  , input  list_pkg::list_id_t    wb_id
  , input  list_pkg::list_state_t wb_state
  // Stage register
  , output logic                  f_vld
  , output list_pkg::list_id_t    f_id
  , output cmd_pkg::op_t          f_op
  , output list_pkg::key_t        f_key
  , output list_pkg::size_t       f_size
  , output logic [1:0]            f_fwd_sel
  , output list_pkg::list_state_t f_fwd_state
);

  logic exe_hit;
  logic wb_hit;

  // Same list still in flight
  assign exe_hit = exe_vld && (exe_id == upt_id);
  assign wb_hit  = wb_vld && (wb_id == upt_id);

  always_ff @(posedge clk) begin
    if (rst) begin
      f_vld <= 1'b0;
    end else begin
      f_vld <= upt_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (upt_vld) begin
      f_id   <= upt_id;
      f_op   <= upt_op;
      f_key  <= upt_key;
      f_size <= upt_size;
      // One-hot, bit 0 from execute, bit 1 from writeback
      // Execute is younger so it wins
      f_fwd_sel <= {wb_hit && !exe_hit, exe_hit};
      f_fwd_state <= exe_hit ? exe_state : wb_state;
    end
  end

endmodule

/* verilog/list_table.sv */
/*
 * List table
 * Synchronous memory of one list state per list id, with one read
 * port and one write port. Read data is registered.
 */
`timescale 1ns/1ns

module list_table (
    input  logic                  clk
  , input  logic                  rd_en
  , input  list_pkg::list_id_t    rd_addr
  , input  logic                  wr_en
  , input  list_pkg::list_id_t    wr_addr
  , input  list_pkg::list_state_t wr_data
  , output list_pkg::list_state_t rd_data
);
  import list_pkg::*;

  list_state_t mem [num_lists];

  // All lists start empty at power-up
  initial begin
    for (int i = 0; i < num_lists; i++) begin
      mem[i] = '0;
    end
  end

  // Write port
  always @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, returns old data on a same-cycle write to the same row
  always @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* verilog/cmd_pkg.sv */
/*
 * Command interface definitions
 * Operation codes of the update channel and the query level width.
 */
package cmd_pkg;

  // Field widths on the command ports
  localparam int op_w    = 2;
  localparam int level_w = 8;

  // Update operations
  typedef enum logic [op_w-1:0] {
    OP_CLEAR   = 2'b00,
    OP_ADD     = 2'b01,
    OP_DELETE  = 2'b10,
    OP_REPLACE = 2'b11
  } op_t;

  // Query slot number
  // Wider than a slot index so out-of-range levels can be requested
  typedef logic [level_w-1:0] level_t;

endpackage

/* verilog/list_pkg.sv */
/*
 * List storage format
 * One list is a fixed array of slots, each holding a valid bit,
 * a key and a size. The table keeps one list state per list id.
 */
package list_pkg;

  // Table geometry
  localparam int num_slots = 4;
  localparam int num_lists = 64;

  // Slot index within a list
  typedef logic [$clog2(num_slots)-1:0] slot_t;

  // Valid slot count, 0 up to num_slots inclusive
  typedef logic [$clog2(num_slots+1)-1:0] count_t;

  // List id, one table row per id
  typedef logic [$clog2(num_lists)-1:0] list_id_t;

  // Payload of one slot
  typedef logic [63:0] key_t;
  typedef logic [31:0] size_t;

  // One slot, 97 bits
  typedef struct packed {
    logic  vld;
    key_t  key;
    size_t size;
  } entry_t;

  // Whole list as stored in one table row, 388 bits
  // Slot 0 is the lowest index
  typedef entry_t [num_slots-1:0] list_state_t;

endpackage
